/* compile.f */
+incdir+hdl
hdl/wht_pkg.sv
hdl/wht_ram_if.sv
hdl/wht_ram.sv
hdl/wht_sink.sv
hdl/wht_butterfly.sv
hdl/wht_source.sv
hdl/wht_mem_top.sv
test/wht_tb.sv

/* hdl/wht_butterfly.sv */
//--------------------------------------------------------------------
// In-place radix-2 butterfly engine
// Runs log2(N) stages of unit-twiddle butterflies over the RAM
// Each pair takes four cycles: read a, read b, write a+b, write a-b
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "wht_defines.svh"

module wht_butterfly (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	wht_ram_if.master bus,
	output logic      done
);

	// N/2 pairs per stage
	localparam int PAIR_W  = `WHT_LOG2N - 1;
	localparam int STAGE_W = $clog2(`WHT_LOG2N);

	logic               active;
	logic               run;
	logic [1:0]         phase;
	logic [PAIR_W-1:0]  pair_cnt;
	logic [STAGE_W-1:0] stage_cnt;
	logic               last_pair;
	logic               last_stage;
	wht_pkg::addr_t     addr_a;
	wht_pkg::addr_t     addr_b;
	wht_pkg::result_t   op_a;

	// Insert bit hi at position stage of the pair index
	function automatic wht_pkg::addr_t pair_addr(
		input logic [PAIR_W-1:0]  pair,
		input logic [STAGE_W-1:0] stage,
		input logic               hi
	);
		wht_pkg::addr_t ext;
		wht_pkg::addr_t low_mask;
		ext      = wht_pkg::addr_t'(pair);
		low_mask = (wht_pkg::addr_t'(1) << stage) - wht_pkg::addr_t'(1);
		// Bits at or above the stage move up by one
		pair_addr = ((ext & ~low_mask) << 1)
		          | (wht_pkg::addr_t'(hi) << stage)
		          | (ext & low_mask);
	endfunction

	// First read issues in the start cycle
	assign run = start | active;

	assign last_pair  = &pair_cnt;
	assign last_stage = (stage_cnt == STAGE_W'(`WHT_LOG2N - 1));

	// Final write of the final stage
	assign done = run & (phase == 2'd3) & last_pair & last_stage;

	// Partner indices differ only in the stage bit
	assign addr_a = pair_addr(pair_cnt, stage_cnt, 1'b0);
	assign addr_b = pair_addr(pair_cnt, stage_cnt, 1'b1);

	//--------------------------------------------------------------------
	// Phase, pair and stage sequencer
	//--------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active    <= 1'b0;
			phase     <= 2'd0;
			pair_cnt  <= '0;
			stage_cnt <= '0;
		end
		else if (run)
		begin
			active <= ~done;
			phase  <= phase + 2'd1;
			if (phase == 2'd3)
			begin
				pair_cnt <= pair_cnt + PAIR_W'(1);
				// Stage advances once all pairs are done
				if (last_pair)
					stage_cnt <= last_stage ? '0 : stage_cnt + STAGE_W'(1);
			end
		end
	end

	// Operand a is on rdata while b is being read
	always_ff @(posedge clk)
	begin
		if (run && phase == 2'd1)
			op_a <= bus.rdata;
	end

	//--------------------------------------------------------------------
	// RAM access
	//--------------------------------------------------------------------
	// Phase bit 1 selects write, bit 0 selects partner b
	// rdata keeps b through both writes since no read is issued
	always_comb
	begin
		bus.rden   = run & ~phase[1];
		bus.rdaddr = phase[0] ? addr_b : addr_a;
		bus.wren   = run & phase[1];
		bus.wraddr = phase[0] ? addr_b : addr_a;
		bus.wdata  = phase[0] ? op_a - bus.rdata : op_a + bus.rdata;
	end

endmodule

/* hdl/wht_defines.svh */
//--------------------------------------------------------------------
// Walsh-Hadamard memory subsystem parameters
// Transform size, stage count and data widths shared by RTL and
// testbench
//--------------------------------------------------------------------

`ifndef WHT_DEFINES_SVH
`define WHT_DEFINES_SVH

// Points per packet, must be a power of two
`define WHT_N 16

// Log2 of the packet size
// Equals the number of butterfly stages and the RAM address width
`define WHT_LOG2N 4

// Signed input sample width
`define WHT_IN_W 12

// Signed result width
// One growth bit per stage, so the transform never overflows
`define WHT_OUT_W (`WHT_IN_W + `WHT_LOG2N)

`endif

/* hdl/wht_mem_top.sv */
//--------------------------------------------------------------------
// Walsh-Hadamard memory top
// Sink, in-place butterfly stages and source over one working RAM
// The FSM hands the RAM to one master at a time
//--------------------------------------------------------------------

`timescale 1ns/100ps

module wht_mem_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic             in_sop,
	input  wht_pkg::sample_t in_data,
	output logic             busy,
	output logic             out_valid,
	output logic             out_sop,
	output logic             out_eop,
	output wht_pkg::result_t out_data
);

	wht_pkg::mem_state_t state;
	wht_pkg::mem_state_t state_r;

	logic sink_start;
	logic calc_start;
	logic src_start;
	logic sink_done;
	logic calc_done;
	logic src_done;

	// Physical RAM port and one bus per master
	wht_ram_if ram_bus ();
	wht_ram_if sink_bus ();
	wht_ram_if bfly_bus ();
	wht_ram_if src_bus ();

	//--------------------------------------------------------------------
	// FSM
	//--------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state   <= wht_pkg::idle;
			state_r <= wht_pkg::idle;
		end
		else
		begin
			state_r <= state;
			case (state)
			wht_pkg::idle   : if (in_valid && in_sop) state <= wht_pkg::sink;
			wht_pkg::sink   : if (sink_done) state <= wht_pkg::calc;
			wht_pkg::calc   : if (calc_done) state <= wht_pkg::source;
			wht_pkg::source : if (src_done) state <= wht_pkg::idle;
			default         : state <= wht_pkg::idle;
			endcase
		end
	end

	// Sink starts on the sop sample itself, which is written as index 0
	assign sink_start = (state == wht_pkg::idle) & in_valid & in_sop;
	// First cycle of calc and source
	assign calc_start = (state == wht_pkg::calc) & (state_r != wht_pkg::calc);
	assign src_start  = (state == wht_pkg::source) & (state_r != wht_pkg::source);

	assign busy = (state != wht_pkg::idle);

	//--------------------------------------------------------------------
	// RAM port switch
	//--------------------------------------------------------------------
	// Sink owns the RAM in idle too, for the sop write
	always_comb
	begin
		case (state)
		wht_pkg::calc :
		begin
			ram_bus.wren   = bfly_bus.wren;
			ram_bus.wraddr = bfly_bus.wraddr;
			ram_bus.wdata  = bfly_bus.wdata;
			ram_bus.rden   = bfly_bus.rden;
			ram_bus.rdaddr = bfly_bus.rdaddr;
		end
		wht_pkg::source :
		begin
			ram_bus.wren   = src_bus.wren;
			ram_bus.wraddr = src_bus.wraddr;
			ram_bus.wdata  = src_bus.wdata;
			ram_bus.rden   = src_bus.rden;
			ram_bus.rdaddr = src_bus.rdaddr;
		end
		default :
		begin
			ram_bus.wren   = sink_bus.wren;
			ram_bus.wraddr = sink_bus.wraddr;
			ram_bus.wdata  = sink_bus.wdata;
			ram_bus.rden   = sink_bus.rden;
			ram_bus.rdaddr = sink_bus.rdaddr;
		end
		endcase
	end

	// Read data back to every master
	assign sink_bus.rdata = ram_bus.rdata;
	assign bfly_bus.rdata = ram_bus.rdata;
	assign src_bus.rdata  = ram_bus.rdata;

	//--------------------------------------------------------------------
	// RAM and masters
	//--------------------------------------------------------------------
	wht_ram ram_i (
		.clk (clk),
		.bus (ram_bus)
	);

	wht_sink sink_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (sink_start),
		.in_valid (in_valid),
		.in_data  (in_data),
		.bus      (sink_bus),
		.done     (sink_done)
	);

	wht_butterfly bfly_i (
		.clk   (clk),
		.rst_n (rst_n),
		.start (calc_start),
		.bus   (bfly_bus),
		.done  (calc_done)
	);

	wht_source src_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (src_start),
		.bus       (src_bus),
		.out_valid (out_valid),
		.out_sop   (out_sop),
		.out_eop   (out_eop),
		.out_data  (out_data),
		.done      (src_done)
	);

endmodule

/* hdl/wht_pkg.sv */
//--------------------------------------------------------------------
// Walsh-Hadamard memory subsystem types
// Sample, result and address vectors plus the top FSM states
//--------------------------------------------------------------------

`include "wht_defines.svh"

package wht_pkg;

	// Input sample as received on the sink port
	typedef logic signed [`WHT_IN_W-1:0] sample_t;

	// RAM word and output word
	// Wide enough for N times the largest input
	typedef logic signed [`WHT_OUT_W-1:0] result_t;

	// RAM address and sample index
	typedef logic [`WHT_LOG2N-1:0] addr_t;

	// Top level FSM
	// idle waits for sop, sink fills the RAM,
	// calc runs the butterfly stages, source drains the RAM
	typedef enum logic [1:0] {
		idle   = 2'd0,
		sink   = 2'd1,
		calc   = 2'd2,
		source = 2'd3
	} mem_state_t;

endpackage

/* hdl/wht_ram.sv */
//--------------------------------------------------------------------
// Working RAM
// Holds one packet of results in place
// Synchronous write and registered read on separate ports
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "wht_defines.svh"

module wht_ram (
	input logic    clk,
	wht_ram_if.ram bus
);

	// One word per transform point
	wht_pkg::result_t mem [`WHT_N];

	//--------------------------------------------------------------------
	// Write port
	//--------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (bus.wren)
			mem[bus.wraddr] <= bus.wdata;
	end

	//--------------------------------------------------------------------
	// Read port
	//--------------------------------------------------------------------
	// Old contents on a same-edge write to the same address
	// rdata holds its value while rden is low
	always_ff @(posedge clk)
	begin
		if (bus.rden)
			bus.rdata <= mem[bus.rdaddr];
	end

endmodule

/* hdl/wht_ram_if.sv */
//--------------------------------------------------------------------
// Working RAM port bundle
// One write port and one read port with registered read data
//--------------------------------------------------------------------

`timescale 1ns/100ps

interface wht_ram_if;

	// Write port
	// Write lands on the edge where wren is high
	logic             wren;
	wht_pkg::addr_t   wraddr;
	wht_pkg::result_t wdata;

	// Read port
	// rdata valid one cycle after an edge with rden high
	logic             rden;
	wht_pkg::addr_t   rdaddr;
	wht_pkg::result_t rdata;

	// Sink, butterfly and source side
	modport master (
		output wren,
		output wraddr,
		output wdata,
		output rden,
		output rdaddr,
		input  rdata
	);

	// Memory side
	modport ram (
		input  wren,
		input  wraddr,
		input  wdata,
		input  rden,
		input  rdaddr,
		output rdata
	);

endinterface

/* hdl/wht_sink.sv */
//--------------------------------------------------------------------
// Packet sink
// Counts the incoming samples of one packet, sign-extends them
// and writes them into the working RAM in arrival order
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "wht_defines.svh"

module wht_sink (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  logic             in_valid,
	input  wht_pkg::sample_t in_data,
	wht_ram_if.master        bus,
	output logic             done
);

	// Index of the next sample
	wht_pkg::addr_t cnt;
	wht_pkg::addr_t wr_addr;
	logic           active;
	logic           take;

	// Start comes with the sop sample, which is index 0
	assign take    = in_valid & (start | active);
	assign wr_addr = start ? '0 : cnt;

	// Nth sample closes the packet
	assign done = take & active & (cnt == wht_pkg::addr_t'(`WHT_N - 1));

	//--------------------------------------------------------------------
	// Sample counter
	//--------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			cnt    <= '0;
		end
		else if (take)
		begin
			// Stop listening after the last sample
			active <= ~done;
			cnt    <= done ? '0 : wr_addr + wht_pkg::addr_t'(1);
		end
	end

	// Write in the same edge the sample arrives
	assign bus.wren   = take;
	assign bus.wraddr = wr_addr;
	assign bus.wdata  = wht_pkg::result_t'(in_data);

	// No reads from the sink
	assign bus.rden   = 1'b0;
	assign bus.rdaddr = '0;

endmodule

/* hdl/wht_source.sv */
//--------------------------------------------------------------------
// Packet source
// Reads the RAM in natural order and emits the packet
// with sop and eop, two cycles after start
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "wht_defines.svh"

module wht_source (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	wht_ram_if.master        bus,
	output logic             out_valid,
	output logic             out_sop,
	output logic             out_eop,
	output wht_pkg::result_t out_data,
	output logic             done
);

	wht_pkg::addr_t cnt;
	logic           active;
	logic           run;
	logic           last_rd;
	// Read strobe and flags aligned with rdata
	logic           rd_dly;
	logic           first_dly;
	logic           last_dly;

	assign run     = start | active;
	assign last_rd = run & (cnt == wht_pkg::addr_t'(`WHT_N - 1));

	// Read address counter
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			cnt    <= '0;
		end
		else if (run)
		begin
			active <= ~last_rd;
			cnt    <= last_rd ? '0 : cnt + wht_pkg::addr_t'(1);
		end
	end

	// RAM latency stage, then output register
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_dly    <= 1'b0;
			first_dly <= 1'b0;
			last_dly  <= 1'b0;
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
			done      <= 1'b0;
		end
		else
		begin
			rd_dly    <= run;
			first_dly <= run & (cnt == '0);
			last_dly  <= last_rd;
			out_valid <= rd_dly;
			out_sop   <= first_dly;
			out_eop   <= last_dly;
			// Done one cycle after eop
			done      <= out_eop;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_dly)
			out_data <= bus.rdata;
	end

	// Read only
	assign bus.rden   = run;
	assign bus.rdaddr = cnt;
	assign bus.wren   = 1'b0;
	assign bus.wraddr = '0;
	assign bus.wdata  = '0;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the Walsh-Hadamard testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps \
	--top-module wht_tb -f compile.f -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vwht_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "test passed"; then
	exit 0
fi

exit 1

/* test/wht_tb.sv */
//--------------------------------------------------------------------
// Walsh-Hadamard memory subsystem testbench
// Feeds a table of packets, with and without input gaps, and
// checks every output word against a reference transform
// Also checks framing, busy and that stray sops are dropped
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "wht_defines.svh"

module wht_tb;

	localparam int IN_W      = `WHT_IN_W;
	localparam int OUT_W     = `WHT_OUT_W;
	localparam int MAX_POS   = (1 << (`WHT_IN_W - 1)) - 1;
	localparam int MIN_NEG   = -(1 << (`WHT_IN_W - 1));
	localparam int TABLE_LEN = 8;
	// Gap cycles per sample are 0 to MAX_GAP
	localparam int MAX_GAP   = 3;
	localparam int MAX_GAPS  = MAX_GAP * `WHT_N;
	localparam int CALC_CYC  = (`WHT_N / 2) * 4 * `WHT_LOG2N;
	localparam int WATCHDOG_CYCLES = TABLE_LEN * (`WHT_N + MAX_GAPS + CALC_CYC + 20) + 50;

	// Sample patterns
	localparam int PAT_ZERO = 0;
	localparam int PAT_IMP0 = 1;
	localparam int PAT_IMP5 = 2;
	localparam int PAT_MAX  = 3;
	localparam int PAT_ALT  = 4;
	localparam int PAT_RAND = 5;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	logic                 in_sop;
	logic [IN_W-1:0]      in_data;
	logic                 busy;
	logic                 out_valid;
	logic                 out_sop;
	logic                 out_eop;
	logic [OUT_W-1:0]     out_data;

	// Stimulus table, one column per field
	int pat_tab [TABLE_LEN] = '{PAT_ZERO, PAT_IMP0, PAT_IMP5, PAT_MAX,
	                            PAT_ALT, PAT_ALT, PAT_RAND, PAT_RAND};
	int gap_tab [TABLE_LEN] = '{0, 0, 1, 0, 0, 1, 0, 1};

	int               samples [`WHT_N];
	logic [OUT_W-1:0] exp_mem [TABLE_LEN][`WHT_N];
	logic [31:0]      rng;
	int               pkt_out;
	int               out_idx;
	int               eop_count;
	int               value_errors;
	int               frame_errors;
	int               busy_errors;

	wht_mem_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_sop    (in_sop),
		.in_data   (in_data),
		.busy      (busy),
		.out_valid (out_valid),
		.out_sop   (out_sop),
		.out_eop   (out_eop),
		.out_data  (out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Plain LCG, 32-bit state
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		lcg_next = s * 32'd1103515245 + 32'd12345;
	endfunction

	// Inputs change 10 ns after the rising edge
	task automatic next_drive_slot();
		@(posedge clk);
		#10;
	endtask

	//--------------------------------------------------------------------
	// Stimulus and reference model
	//--------------------------------------------------------------------
	task automatic build_packet(input int p);
		int sum;
		for (int n = 0; n < `WHT_N; n++)
		begin
			case (pat_tab[p])
			PAT_IMP0 : samples[n] = (n == 0) ? 1234 : 0;
			PAT_IMP5 : samples[n] = (n == 5) ? -777 : 0;
			PAT_MAX  : samples[n] = MAX_POS;
			PAT_ALT  : samples[n] = (n % 2 == 0) ? MAX_POS : MIN_NEG;
			PAT_RAND :
			begin
				rng = lcg_next(rng);
				samples[n] = int'($signed(rng[27:16]));
			end
			default  : samples[n] = 0;
			endcase
		end
		// Sign flips where n AND k has odd parity
		for (int k = 0; k < `WHT_N; k++)
		begin
			sum = 0;
			for (int n = 0; n < `WHT_N; n++)
				sum = ($countones(n & k) % 2 == 1) ? sum - samples[n] : sum + samples[n];
			exp_mem[p][k] = OUT_W'(sum);
		end
	endtask

	task automatic feed_packet(input int p);
		int gap;
		if (busy)
		begin
			busy_errors++;
			$display("busy is high before packet %0d starts", p);
		end
		for (int n = 0; n < `WHT_N; n++)
		begin
			if (gap_tab[p] != 0 && n > 0)
			begin
				rng = lcg_next(rng);
				gap = int'(rng[17:16]);
				in_valid = 1'b0;
				repeat (gap) next_drive_slot();
			end
			in_valid = 1'b1;
			in_sop   = (n == 0);
			in_data  = IN_W'(samples[n]);
			next_drive_slot();
			// Accepting sop edge has passed
			if (n == 0 && !busy)
			begin
				busy_errors++;
				$display("busy did not rise after sop of packet %0d", p);
			end
		end
		in_valid = 1'b0;
		in_sop   = 1'b0;
		// Stray sop during calc, must be dropped
		repeat (4) next_drive_slot();
		in_valid = 1'b1;
		in_sop   = 1'b1;
		in_data  = 12'h5a5;
		next_drive_slot();
		in_valid = 1'b0;
		in_sop   = 1'b0;
	endtask

	//--------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------
	initial
	begin
		int fall_wait;
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		in_sop       = 1'b0;
		in_data      = '0;
		rng          = 32'd61777;
		pkt_out      = 0;
		out_idx      = 0;
		eop_count    = 0;
		value_errors = 0;
		frame_errors = 0;
		busy_errors  = 0;
		repeat (8) @(posedge clk);
		#10;
		rst_n = 1'b1;
		next_drive_slot();
		if (busy || out_valid)
		begin
			busy_errors++;
			$display("busy or out_valid is high after reset");
		end

		for (int p = 0; p < TABLE_LEN; p++)
		begin
			build_packet(p);
			feed_packet(p);
			// Wait for the monitor to close this packet
			while (pkt_out <= p)
				next_drive_slot();
			fall_wait = 0;
			while (busy && fall_wait < 4)
			begin
				next_drive_slot();
				fall_wait++;
			end
			if (busy)
			begin
				busy_errors++;
				$display("busy stayed high after eop of packet %0d", p);
			end
		end

		repeat (20) next_drive_slot();
		if (busy)
		begin
			busy_errors++;
			$display("busy is high after the last packet");
		end
		if (eop_count != TABLE_LEN)
		begin
			frame_errors++;
			$display("saw %0d packets with eop instead of %0d", eop_count, TABLE_LEN);
		end
		$display("errors: value %0d, framing %0d, busy %0d",
		         value_errors, frame_errors, busy_errors);
		if (value_errors + frame_errors + busy_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	//--------------------------------------------------------------------
	// Output monitor, sampled mid-cycle
	//--------------------------------------------------------------------
	always @(negedge clk)
	begin
		if (rst_n && out_valid)
		begin
			if (!busy)
			begin
				busy_errors++;
				$display("busy is low while out_valid is high");
			end
			if (pkt_out >= TABLE_LEN)
			begin
				frame_errors++;
				$display("output word seen after the last packet");
			end
			else if (out_data !== exp_mem[pkt_out][out_idx])
			begin
				value_errors++;
				$display("[ERROR] out_data packet %0d index 0x%h expected 0x%h actual 0x%h",
				         pkt_out, out_idx, exp_mem[pkt_out][out_idx], out_data);
			end
			if (out_idx == 0 && !out_sop)
			begin
				frame_errors++;
				$display("sop missing on the first word of packet %0d", pkt_out);
			end
			if (out_idx != 0 && out_sop)
			begin
				frame_errors++;
				$display("extra sop inside packet %0d", pkt_out);
			end
			if (out_idx == `WHT_N - 1 && !out_eop)
			begin
				frame_errors++;
				$display("eop missing on the last word of packet %0d", pkt_out);
			end
			if (out_idx != `WHT_N - 1 && out_eop)
			begin
				frame_errors++;
				$display("extra eop inside packet %0d", pkt_out);
			end
			if (out_eop)
				eop_count++;
			if (out_idx == `WHT_N - 1)
			begin
				out_idx = 0;
				pkt_out++;
			end
			else
				out_idx++;
		end
		else if (rst_n)
		begin
			// Valid must not drop inside a packet
			if (out_idx != 0)
			begin
				frame_errors++;
				$display("out_valid dropped after %0d words of packet %0d", out_idx, pkt_out);
				out_idx = 0;
				pkt_out++;
			end
			if (out_sop || out_eop)
			begin
				frame_errors++;
				$display("sop or eop is high while out_valid is low");
			end
		end
	end

	// Bound on the whole run
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("run timed out after %0d cycles before all packets were checked",
		         WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule
